// ==== gamePkg.sv ====
////////////////////////////////////////////////////////////
// shared constants and types of the sprite motion core
// modules import it in their body, port lists use gamePkg::
////////////////////////////////////////////////////////////
package gamePkg;

	// fixed point, positions kept in 1/64 pixel
	localparam int FIXED_POINT_MULTIPLIER = 64; // must be 2^n
	localparam int FP_SHIFT = $clog2(FIXED_POINT_MULTIPLIER);
	localparam int COORD_WIDTH = 11; // signed pixels, covers the 640x480 arena
	localparam int SPEED_WIDTH = 12; // signed subpixels per frame
	localparam int FIXED_WIDTH = COORD_WIDTH + FP_SHIFT;

	typedef logic signed [COORD_WIDTH-1:0] coordT;
	typedef logic signed [SPEED_WIDTH-1:0] speedT;
	typedef logic signed [FIXED_WIDTH-1:0] fixedT; // integer part on top of FP_SHIFT bits

	// arena wall lines in pixels
	localparam coordT ARENA_LEFT = 0;
	localparam coordT ARENA_TOP = 0;
	localparam coordT ARENA_RIGHT = 639;
	localparam coordT ARENA_BOTTOM = 479;

	localparam coordT SPRITE_SIZE = 32; // square sprite
	localparam coordT SPRITE_HALF = SPRITE_SIZE >>> 1; // centre offset

	// the one fixed brick, inclusive bounds
	localparam coordT BRICK_LEFT = 288;
	localparam coordT BRICK_TOP = 352;
	localparam coordT BRICK_RIGHT = 351;
	localparam coordT BRICK_BOTTOM = 383;

	// top-left corner after reset, clear of walls and brick
	localparam coordT INITIAL_X = 100;
	localparam coordT INITIAL_Y = 100;

	// motion constants, subpixels per frame
	localparam speedT RUN_SPEED = 128;  // 2 px per frame
	localparam speedT JUMP_SPEED = 512; // upward kick
	localparam speedT Y_ACCEL = 16;     // gravity per frame
	localparam speedT MAX_SPEED = 1024; // limit on |xSpeed| and |ySpeed|

	typedef enum logic [2:0] {Sidle, Sleft, Sright, Sjump, Sdie} motionStateT;

	// one bit per sprite edge, {left, top, right, bottom}
	typedef struct packed {
		logic left;
		logic top;
		logic right;
		logic bottom;
	} hitEdgeT;

	typedef struct packed {
		coordT x;
		coordT y;
	} spritePosT;

endpackage

// ==== playerControl.sv ====
////////////////////////////////////////////////////////////
// turns the four key levels into one motion state per frame
// keys are sampled on the startOfFrame cycle only
////////////////////////////////////////////////////////////
module playerControl (
	input logic clk,
	input logic resetN,
	input logic startOfFrame, // one clock pulse per frame
	input logic keyLeft,
	input logic keyRight,
	input logic keyJump,
	input logic keyDie,
	output gamePkg::motionStateT motionState
);
	import gamePkg::*;

	motionStateT nextState; // state requested by the keys this frame
	logic jumpHeld;         // jump key level seen at the previous frame start

	// priority: die, fresh jump, single direction, idle
	always_comb begin
		nextState = Sidle;
		if (motionState == Sdie || keyDie) begin
			nextState = Sdie; // sticky until reset
		end
		else if (keyJump && !jumpHeld) begin
			nextState = Sjump; // only on a new press
		end
		else if (keyLeft && !keyRight) begin
			nextState = Sleft;
		end
		else if (keyRight && !keyLeft) begin
			nextState = Sright;
		end
		// both directions together fall through to Sidle
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			motionState <= Sidle;
			jumpHeld <= 1'b0;
		end
		else if (startOfFrame) begin
			motionState <= nextState; // visible from the next clock
			jumpHeld <= keyJump;      // a held key can not retrigger
		end
	end

	// a jump lasts one frame: next frame the key is already held,
	// so the edge test above fails and the direction keys decide

endmodule

// ==== tileCollider.sv ====
////////////////////////////////////////////////////////////
// combinational hit code of the sprite against walls and brick
// hitEdge is valid in the same cycle as position
////////////////////////////////////////////////////////////
module tileCollider (
	input gamePkg::spritePosT position,
	output gamePkg::hitEdgeT hitEdge
);
	import gamePkg::*;

	coordT spriteRight;  // last pixel column of the sprite
	coordT spriteBottom; // last pixel row of the sprite
	coordT centreX;
	coordT centreY;
	hitEdgeT wallHit;
	hitEdgeT brickHit;
	logic brickOverlap;

	assign spriteRight = position.x + SPRITE_SIZE - 11'sd1;
	assign spriteBottom = position.y + SPRITE_SIZE - 11'sd1;
	assign centreX = position.x + SPRITE_HALF;
	assign centreY = position.y + SPRITE_HALF;

	// touching a wall line counts as a hit
	always_comb begin
		wallHit.left = (position.x <= ARENA_LEFT);
		wallHit.top = (position.y <= ARENA_TOP);
		wallHit.right = (spriteRight >= ARENA_RIGHT);
		wallHit.bottom = (spriteBottom >= ARENA_BOTTOM);
	end

	// inclusive rectangles, so a shared pixel is an overlap
	assign brickOverlap = (position.x <= BRICK_RIGHT) &&
		(spriteRight >= BRICK_LEFT) &&
		(position.y <= BRICK_BOTTOM) &&
		(spriteBottom >= BRICK_TOP);

	// pick the sprite side that crosses the brick's nearest edge
	always_comb begin
		brickHit = '0;
		if (brickOverlap) begin
			brickHit.bottom = (BRICK_TOP > centreY);   // brick lies below the centre
			brickHit.top = (BRICK_BOTTOM < centreY);   // brick lies above
			brickHit.right = (BRICK_LEFT > centreX);   // brick to the right
			brickHit.left = (BRICK_RIGHT < centreX);   // brick to the left
		end
		// a corner hit sets two bits, a centre inside the brick span sets none on that axis
	end

	assign hitEdge = wallHit | brickHit; // walls and brick merged per edge

endmodule

// ==== bumpyAnimator.sv ====
////////////////////////////////////////////////////////////
// fixed-point speed and position of the sprite
// updated once per startOfFrame from motion state and hit code
////////////////////////////////////////////////////////////
module bumpyAnimator (
	input logic clk,
	input logic resetN,
	input logic startOfFrame, // one clock pulse per frame
	input gamePkg::motionStateT motionState,
	input gamePkg::hitEdgeT hitEdge,
	output gamePkg::spritePosT position // top-left corner in pixels
);
	import gamePkg::*;

	speedT xSpeed; // subpixels per frame, positive to the right
	speedT ySpeed; // positive is downward
	speedT xSpeedNext;
	speedT ySpeedNext;
	fixedT xFixed; // top-left x in 1/64 pixel
	fixedT yFixed;

	// limit a speed to +-MAX_SPEED
	function automatic speedT clampSpeed(input speedT speed);
		speedT limited;
		limited = speed;
		if (speed > MAX_SPEED) begin
			limited = MAX_SPEED;
		end
		else if (speed < -MAX_SPEED) begin
			limited = -MAX_SPEED;
		end
		return limited;
	endfunction

	// next speeds from intent, gravity, bounce and clamp, in that order
	always_comb begin
		// horizontal intent
		case (motionState)
			Sleft: xSpeedNext = -RUN_SPEED;
			Sright: xSpeedNext = RUN_SPEED;
			default: xSpeedNext = xSpeed; // idle and jump keep the drift
		endcase

		// jump only from the ground, otherwise gravity
		if (motionState == Sjump && hitEdge.bottom) begin
			ySpeedNext = -JUMP_SPEED;
		end
		else begin
			ySpeedNext = ySpeed + Y_ACCEL;
		end

		// bounce only when moving into the edge that is hit
		if ((hitEdge.left && xSpeedNext < 0) || (hitEdge.right && xSpeedNext > 0)) begin
			xSpeedNext = -xSpeedNext;
		end
		if ((hitEdge.top && ySpeedNext < 0) || (hitEdge.bottom && ySpeedNext > 0)) begin
			ySpeedNext = -ySpeedNext;
		end

		xSpeedNext = clampSpeed(xSpeedNext);
		ySpeedNext = clampSpeed(ySpeedNext);
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			xSpeed <= '0;
			ySpeed <= '0;
			xFixed <= {INITIAL_X, {FP_SHIFT{1'b0}}}; // pixels times 64
			yFixed <= {INITIAL_Y, {FP_SHIFT{1'b0}}};
		end
		else if (startOfFrame && motionState != Sdie) begin // dead sprite stays frozen
			xSpeed <= xSpeedNext;
			ySpeed <= ySpeedNext;
			// integrate with the new speeds
			xFixed <= xFixed + fixedT'(xSpeedNext);
			yFixed <= yFixed + fixedT'(ySpeedNext);
		end
	end

	// upper bits are the arithmetic shift by FP_SHIFT, so this floors
	assign position.x = xFixed[FIXED_WIDTH-1:FP_SHIFT];
	assign position.y = yFixed[FIXED_WIDTH-1:FP_SHIFT];

endmodule

// ==== bumpyGame.sv ====
////////////////////////////////////////////////////////////
// top of the motion core: controller, animator and collider
// startOfFrame and the key levels come from outside
////////////////////////////////////////////////////////////
module bumpyGame (
	input logic clk,
	input logic resetN,
	input logic startOfFrame,
	input logic keyLeft,
	input logic keyRight,
	input logic keyJump,
	input logic keyDie,
	output gamePkg::spritePosT position,
	output gamePkg::hitEdgeT hitEdge,
	output gamePkg::motionStateT motionState
);

	playerControl control (
		.clk(clk),
		.resetN(resetN),
		.startOfFrame(startOfFrame),
		.keyLeft(keyLeft),
		.keyRight(keyRight),
		.keyJump(keyJump),
		.keyDie(keyDie),
		.motionState(motionState) // registered one frame ahead of the animator
	);

	bumpyAnimator animator (
		.clk(clk),
		.resetN(resetN),
		.startOfFrame(startOfFrame),
		.motionState(motionState),
		.hitEdge(hitEdge),
		.position(position)
	);

	// hit code closes the loop back to the animator in the same cycle
	tileCollider collider (
		.position(position),
		.hitEdge(hitEdge)
	);

endmodule

// ==== bumpyChecker.sv ====
////////////////////////////////////////////////////////////
// watches the sprite core ports and runs its own model
// hitEdge checked every clock, position and state per frame
////////////////////////////////////////////////////////////
module bumpyChecker (
	input logic clk,
	input logic resetN,
	input logic startOfFrame,
	input logic keyLeft,
	input logic keyRight,
	input logic keyJump,
	input logic keyDie,
	input gamePkg::spritePosT position,
	input gamePkg::hitEdgeT hitEdge,
	input gamePkg::motionStateT motionState,
	input int testId, // which behaviour the stimulus is on
	output int errorCount,
	output int checkCount
);
	import gamePkg::*;

	typedef struct packed {
		int xSpeed; // subpixels per frame
		int ySpeed;
		int xFixed; // 1/64 pixel
		int yFixed;
	} motionModelT;

	localparam int spriteSize = int'(SPRITE_SIZE);
	localparam int runSpeed = int'(RUN_SPEED);
	localparam int jumpSpeed = int'(JUMP_SPEED);
	localparam int yAccel = int'(Y_ACCEL);
	localparam int maxSpeed = int'(MAX_SPEED);

	motionModelT model;
	motionStateT modelState;
	logic jumpHeld;         // jump key at the previous frame start
	int frameCount = 0;     // bumps on each model update
	int checkedFrame = 0;
	int errors = 0;
	int checks = 0;
	hitEdgeT expHit;
	spritePosT expPos;

	assign errorCount = errors;
	assign checkCount = checks;

	function automatic string testName(input int id);
		case (id)
			1: return "reset";
			2: return "gravity";
			3: return "running";
			4: return "jump";
			5: return "brick";
			6: return "death";
			7: return "second reset";
			default: return "unknown";
		endcase
	endfunction

	// collider rule: walls by touch, brick by overlap and side of the centre
	function automatic hitEdgeT expectedHitEdge(input int px, input int py);
		hitEdgeT hit;
		int lastX;
		int lastY;
		int midX;
		int midY;
		lastX = px + spriteSize - 1;
		lastY = py + spriteSize - 1;
		midX = px + spriteSize / 2;
		midY = py + spriteSize / 2;
		hit.left = (px <= int'(ARENA_LEFT));
		hit.top = (py <= int'(ARENA_TOP));
		hit.right = (lastX >= int'(ARENA_RIGHT));
		hit.bottom = (lastY >= int'(ARENA_BOTTOM));
		if (px <= int'(BRICK_RIGHT) && lastX >= int'(BRICK_LEFT) &&
			py <= int'(BRICK_BOTTOM) && lastY >= int'(BRICK_TOP)) begin
			hit.left = hit.left | (int'(BRICK_RIGHT) < midX);
			hit.right = hit.right | (int'(BRICK_LEFT) > midX);
			hit.top = hit.top | (int'(BRICK_BOTTOM) < midY);
			hit.bottom = hit.bottom | (int'(BRICK_TOP) > midY); // brick under the centre
		end
		return hit;
	endfunction

	// one frame of the animator: intent, gravity, bounce, clamp, integrate
	function automatic motionModelT nextMotion(input motionModelT cur, input motionStateT state,
		input hitEdgeT hit);
		motionModelT nxt;
		nxt = cur;
		if (state == Sdie) begin
			return cur; // frozen
		end
		if (state == Sleft) nxt.xSpeed = -runSpeed;
		if (state == Sright) nxt.xSpeed = runSpeed;
		if (state == Sjump && hit.bottom) begin
			nxt.ySpeed = -jumpSpeed;
		end
		else begin
			nxt.ySpeed = cur.ySpeed + yAccel;
		end
		if ((hit.left && nxt.xSpeed < 0) || (hit.right && nxt.xSpeed > 0)) nxt.xSpeed = -nxt.xSpeed;
		if ((hit.top && nxt.ySpeed < 0) || (hit.bottom && nxt.ySpeed > 0)) nxt.ySpeed = -nxt.ySpeed;
		if (nxt.xSpeed > maxSpeed) nxt.xSpeed = maxSpeed;
		if (nxt.xSpeed < -maxSpeed) nxt.xSpeed = -maxSpeed;
		if (nxt.ySpeed > maxSpeed) nxt.ySpeed = maxSpeed;
		if (nxt.ySpeed < -maxSpeed) nxt.ySpeed = -maxSpeed;
		nxt.xFixed = cur.xFixed + nxt.xSpeed;
		nxt.yFixed = cur.yFixed + nxt.ySpeed;
		return nxt;
	endfunction

	// key priority: die, new jump press, one direction, idle
	function automatic motionStateT nextState(input motionStateT cur, input logic held,
		input logic left, input logic right, input logic jump, input logic die);
		if (cur == Sdie || die) return Sdie;
		if (jump && !held) return Sjump;
		if (left && !right) return Sleft;
		if (right && !left) return Sright;
		return Sidle; // none, or both directions
	endfunction

	always @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			model.xSpeed <= 0;
			model.ySpeed <= 0;
			model.xFixed <= int'(INITIAL_X) * FIXED_POINT_MULTIPLIER;
			model.yFixed <= int'(INITIAL_Y) * FIXED_POINT_MULTIPLIER;
			modelState <= Sidle;
			jumpHeld <= 1'b0;
			frameCount <= frameCount + 1; // reset values get compared as well
		end
		else if (startOfFrame) begin
			model <= nextMotion(model, modelState, expectedHitEdge($signed(model.xFixed) >>> FP_SHIFT,
				$signed(model.yFixed) >>> FP_SHIFT));
			modelState <= nextState(modelState, jumpHeld, keyLeft, keyRight, keyJump, keyDie);
			jumpHeld <= keyJump;
			frameCount <= frameCount + 1;
		end
	end

	// outputs only move on the rising edge, so the falling edge sees them settled
	always @(negedge clk) begin
		expHit = expectedHitEdge($signed(model.xFixed) >>> FP_SHIFT, $signed(model.yFixed) >>> FP_SHIFT);
		checks = checks + 1;
		if (hitEdge != expHit) begin
			errors = errors + 1;
			$display("CHECK FAILED %s hitEdge expected %b actual %b at %0t", testName(testId),
				expHit, hitEdge, $time);
		end
		if (frameCount != checkedFrame) begin // a frame or a reset happened since the last look
			checkedFrame = frameCount;
			expPos.x = coordT'($signed(model.xFixed) >>> FP_SHIFT);
			expPos.y = coordT'($signed(model.yFixed) >>> FP_SHIFT);
			checks = checks + 2;
			if (position != expPos) begin
				errors = errors + 1;
				$display("CHECK FAILED %s position expected (%0d,%0d) actual (%0d,%0d) at %0t",
					testName(testId), expPos.x, expPos.y, position.x, position.y, $time);
			end
			if (motionState != modelState) begin
				errors = errors + 1;
				$display("CHECK FAILED %s motionState expected %s actual %s at %0t",
					testName(testId), modelState.name(), motionState.name(), $time);
			end
		end
	end

endmodule

// ==== bumpyGame_tb.sv ====
////////////////////////////////////////////////////////////
// testbench of the sprite motion core, one frame per 16 clocks
// directed key phases, then xorshift keys, then death and reset
////////////////////////////////////////////////////////////
module bumpyGame_tb;
	import gamePkg::*;

	typedef struct packed {
		logic die;
		logic jump;
		logic right;
		logic left;
	} keySetT;

	localparam int frameCycles = 16;
	localparam int idleFrames = 70;   // enough to fall onto the floor
	localparam int rightFrames = 280; // reaches the right wall
	localparam int jumpFrames = 150;  // held key, then taps
	localparam int randomFrames = 400;
	localparam int deathFrames = 40;
	localparam int resetFrames = 10;
	localparam int totalFrames = idleFrames + rightFrames + jumpFrames + randomFrames +
		deathFrames + resetFrames;
	localparam int timeoutTime = (totalFrames * frameCycles + 200) * 20;
	localparam keySetT noKeys = keySetT'(4'b0000);
	localparam keySetT rightKey = keySetT'(4'b0010);
	localparam keySetT jumpKey = keySetT'(4'b0100);
	localparam keySetT dieKey = keySetT'(4'b1000);

	logic clk = 1'b0;
	logic resetN;
	logic startOfFrame;
	keySetT keyState;
	spritePosT position;
	hitEdgeT hitEdge;
	motionStateT motionState;
	int testId;
	int errorCount;
	int checkCount;
	logic [31:0] seed = 32'd2;

	always #10 clk = ~clk;

	bumpyGame DUT (
		.clk(clk),
		.resetN(resetN),
		.startOfFrame(startOfFrame),
		.keyLeft(keyState.left),
		.keyRight(keyState.right),
		.keyJump(keyState.jump),
		.keyDie(keyState.die),
		.position(position),
		.hitEdge(hitEdge),
		.motionState(motionState)
	);

	bumpyChecker scoreboard (
		.clk(clk),
		.resetN(resetN),
		.startOfFrame(startOfFrame),
		.keyLeft(keyState.left),
		.keyRight(keyState.right),
		.keyJump(keyState.jump),
		.keyDie(keyState.die),
		.position(position),
		.hitEdge(hitEdge),
		.motionState(motionState),
		.testId(testId),
		.errorCount(errorCount),
		.checkCount(checkCount)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// keys change together with the one-cycle frame pulse
	task automatic playFrames(input int count, input keySetT keys);
		repeat (count) begin
			@(negedge clk);
			startOfFrame <= 1'b1;
			keyState <= keys;
			@(negedge clk);
			startOfFrame <= 1'b0;
			repeat (frameCycles - 2) @(negedge clk);
		end
	endtask

	task automatic playRandom(input int frames, input logic allowDie);
		int framesLeft;
		int hold;
		keySetT pattern;
		framesLeft = frames;
		while (framesLeft > 0) begin
			seed = xorshift(seed);
			pattern = keySetT'(seed[3:0]);
			if (!allowDie) pattern.die = 1'b0;
			hold = int'(seed[10:8]) + 1; // 1 to 8 frames
			if (hold > framesLeft) hold = framesLeft;
			playFrames(hold, pattern);
			framesLeft = framesLeft - hold;
		end
	endtask

	initial begin
		resetN = 1'b0;
		startOfFrame = 1'b0;
		keyState = noKeys;
		testId = 1;
		repeat (5) @(posedge clk); // five full clocks in reset
		@(negedge clk);
		resetN <= 1'b1;
		playFrames(5, noKeys);
		testId <= 2;
		playFrames(idleFrames - 5, noKeys);
		testId <= 3;
		playFrames(rightFrames, rightKey);
		testId <= 4;
		playFrames(60, jumpKey); // held, one jump at most
		repeat (30) begin
			playFrames(1, jumpKey);
			playFrames(2, noKeys);
		end
		testId <= 5;
		playRandom(randomFrames, 1'b0);
		testId <= 6;
		playFrames(1, dieKey);
		playRandom(deathFrames - 1, 1'b1); // anything goes once dead
		testId <= 7;
		@(negedge clk);
		resetN <= 1'b0;
		keyState <= noKeys;
		repeat (5) @(negedge clk);
		resetN <= 1'b1;
		playFrames(resetFrames, noKeys);
		repeat (2) @(negedge clk);
		$display("checks %0d, errors %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("all tests passed");
		end
		else begin
			$display("tests failed");
		end
		$finish;
	end

	// whole sequence plus a margin of 200 clocks
	initial begin
		#(timeoutTime);
		$display("watchdog expired, stimulus did not finish in time");
		$display("tests failed");
		$finish;
	end

endmodule

// ==== bumpyGame.f ====
gamePkg.sv
playerControl.sv
tileCollider.sv
bumpyAnimator.sv
bumpyGame.sv
bumpyChecker.sv
bumpyGame_tb.sv

// ==== run.sh ====
#!/bin/bash
# build the testbench with Verilator, run it, then search the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --top-module bumpyGame_tb -f bumpyGame.f -o simBumpy \
	&& ./obj_dir/simBumpy > sim.log 2>&1 \
	|| { echo "build or run error"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -qx "all tests passed" sim.log \
	&& echo "PASS" \
	|| { echo "FAIL"; exit 1; }
